/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ntt_coproc_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/ntt_pkg.sv
src/ntt_fifo.sv
src/ntt_axil_frontend.sv
src/ntt_butterfly.sv
src/ntt_coproc_top.sv
tests/tb_clock_gen.sv
tests/ntt_coproc_tb.sv

/* src/ntt_axil_frontend.sv */
// AXI4-Lite slave holding the operands, queuing jobs and returning results
`timescale 1ns/100ps
`default_nettype none

module ntt_axil_frontend (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  ntt_pkg::axil_addr_t  awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  ntt_pkg::axil_data_t  wdata_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output ntt_pkg::axil_resp_t  bresp_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  input  ntt_pkg::axil_addr_t  araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output ntt_pkg::axil_data_t  rdata_o,
  output ntt_pkg::axil_resp_t  rresp_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output logic                 job_push_o,
  output ntt_pkg::ntt_job_t    job_data_o,
  input  logic                 job_full_i,
  output logic                 res_pop_o,
  input  ntt_pkg::ntt_result_t res_head_i,
  input  logic                 res_empty_i
);
  import ntt_pkg::*;

  // Per-channel handshake state
  typedef enum logic {
    CH_IDLE,
    CH_RESP
  } chan_state_e;

  chan_state_e wr_state;
  chan_state_e rd_state;
  coef_t       opu_q;
  coef_t       opv_q;
  coef_t       opw_q;
  logic        opu_we;
  logic        opv_we;
  logic        opw_we;
  logic        operand_ok;
  logic        mode_ok;
  axil_resp_t  wr_resp_d;
  axil_resp_t  rd_resp_d;
  axil_data_t  rd_data_d;

  // AW and W are taken together, one write at a time
  assign awready_o = (wr_state == CH_IDLE) && awvalid_i && wvalid_i;
  assign wready_o  = awready_o;
  assign bvalid_o  = (wr_state == CH_RESP);
  // AR accepted only while no read data is pending
  assign arready_o = (rd_state == CH_IDLE) && arvalid_i;
  assign rvalid_o  = (rd_state == CH_RESP);

  // Operands must already be reduced below q
  assign operand_ok = (wdata_i < axil_data_t'(NTT_Q));
  assign mode_ok    = (wdata_i[2:0] <= 3'(MODE_PWS));

  // Job is the stored operands plus the control word being written
  assign job_data_o = '{opu: opu_q, opv: opv_q, opw: opw_q,
                        mode: ntt_mode_e'(wdata_i[2:0]), accumulate: wdata_i[3]};

  // Write decode
  always_comb begin
    wr_resp_d  = RESP_OKAY;
    opu_we     = 1'b0;
    opv_we     = 1'b0;
    opw_we     = 1'b0;
    job_push_o = 1'b0;
    if (awready_o) begin
      case (awaddr_i)
        REG_OPU:  if (operand_ok) opu_we = 1'b1; else wr_resp_d = RESP_SLVERR;
        REG_OPV:  if (operand_ok) opv_we = 1'b1; else wr_resp_d = RESP_SLVERR;
        REG_OPW:  if (operand_ok) opw_we = 1'b1; else wr_resp_d = RESP_SLVERR;
        // Job queued in the same cycle as the handshake
        REG_CTRL: begin
          if (mode_ok && !job_full_i) begin
            job_push_o = 1'b1;
          end else begin
            wr_resp_d = RESP_SLVERR;
          end
        end
        default:  wr_resp_d = RESP_SLVERR;
      endcase
    end
  end

  // Read decode, RES_V pops only when a result is present
  always_comb begin
    rd_data_d = '0;
    rd_resp_d = RESP_OKAY;
    res_pop_o = 1'b0;
    case (araddr_i)
      REG_RES_U: begin
        if (res_empty_i) rd_resp_d = RESP_SLVERR;
        else rd_data_d = axil_data_t'(res_head_i.u);
      end
      REG_RES_V: begin
        if (res_empty_i) begin
          rd_resp_d = RESP_SLVERR;
        end else begin
          rd_data_d = axil_data_t'(res_head_i.v);
          res_pop_o = arready_o;
        end
      end
      REG_STATUS: rd_data_d = axil_data_t'({res_empty_i, job_full_i});
      default:    rd_resp_d = RESP_SLVERR;
    endcase
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      opu_q <= '0;
      opv_q <= '0;
      opw_q <= '0;
    end else begin
      if (opu_we) opu_q <= wdata_i[COEF_W-1:0];
      if (opv_we) opv_q <= wdata_i[COEF_W-1:0];
      if (opw_we) opw_q <= wdata_i[COEF_W-1:0];
    end
  end

  // Channel state machines
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_state <= CH_IDLE;
      rd_state <= CH_IDLE;
    end else begin
      if (wr_state == CH_IDLE) begin
        if (awready_o) wr_state <= CH_RESP;
      end else if (bready_i) begin
        wr_state <= CH_IDLE;
      end
      if (rd_state == CH_IDLE) begin
        if (arready_o) rd_state <= CH_RESP;
      end else if (rready_i) begin
        rd_state <= CH_IDLE;
      end
    end
  end

  // Response payload captured at the handshake
  always_ff @(posedge clk) begin
    if (awready_o) bresp_o <= wr_resp_d;
    if (arready_o) begin
      rdata_o <= rd_data_d;
      rresp_o <= rd_resp_d;
    end
  end

  // Write response held stable until the host accepts it
  bvalid_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

`default_nettype wire

/* src/ntt_butterfly.sv */
// Four-stage mod-q butterfly pipeline, frozen while the result buffer is full
`timescale 1ns/100ps
`default_nettype none

module ntt_butterfly (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  ntt_pkg::ntt_job_t    job_head_i,
  input  logic                 job_empty_i,
  output logic                 job_pop_o,
  output logic                 res_push_o,
  output ntt_pkg::ntt_result_t res_data_o,
  input  logic                 res_full_i
);
  import ntt_pkg::*;

  // a + b mod q, inputs below q
  function automatic coef_t mod_add(coef_t a, coef_t b);
    logic [COEF_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, NTT_Q}) s = s - {1'b0, NTT_Q};
    return s[COEF_W-1:0];
  endfunction

  // a - b mod q, wraps negative differences back into the field
  function automatic coef_t mod_sub(coef_t a, coef_t b);
    logic [COEF_W:0] d;
    d = {1'b0, a} - {1'b0, b};
    if (a < b) d = d + {1'b0, NTT_Q};
    return d[COEF_W-1:0];
  endfunction

  // Reduce a 46-bit product by folding 2^23 = 2^13 - 1 three times
  function automatic coef_t mod_reduce(prod_t x);
    logic [36:0] f1;
    logic [26:0] f2;
    logic [23:0] f3;
    f1 = 37'(x[45:23]) * 37'(NTT_FOLD) + 37'(x[22:0]);
    f2 = 27'(f1[36:23]) * 27'(NTT_FOLD) + 27'(f1[22:0]);
    // After three folds the value is below 2q
    f3 = 24'(f2[26:23]) * 24'(NTT_FOLD) + 24'(f2[22:0]);
    if (f3 >= 24'(NTT_Q)) f3 = f3 - 24'(NTT_Q);
    return f3[COEF_W-1:0];
  endfunction

  logic        advance;
  logic        s1_valid, s2_valid, s3_valid, s4_valid;
  ntt_mode_e   s1_mode, s2_mode, s3_mode;
  coef_t       s1_ma, s1_mb, s1_add;
  coef_t       s2_add, s3_add, s3_prod;
  prod_t       s2_prod;
  coef_t       ma_d, mb_d, add_d;
  ntt_result_t res_d;

  // Whole pipeline freezes when the last result cannot leave
  assign advance    = !(s4_valid && res_full_i);
  assign job_pop_o  = advance && !job_empty_i;
  assign res_push_o = s4_valid && !res_full_i;

  // Stage 1 operand selection by mode
  always_comb begin
    ma_d  = '0;
    mb_d  = '0;
    add_d = job_head_i.opu;
    case (job_head_i.mode)
      MODE_CT: begin
        ma_d = job_head_i.opv;
        mb_d = job_head_i.opw;
      end
      // GS multiplies the plain difference, sum goes straight through
      MODE_GS: begin
        ma_d  = mod_sub(job_head_i.opu, job_head_i.opv);
        mb_d  = job_head_i.opw;
        add_d = mod_add(job_head_i.opu, job_head_i.opv);
      end
      MODE_PWM: begin
        ma_d  = job_head_i.opu;
        mb_d  = job_head_i.opv;
        add_d = job_head_i.accumulate ? job_head_i.opw : '0;
      end
      // Pointwise add and subtract leave the multiplier at zero
      MODE_PWA: add_d = mod_add(job_head_i.opu, job_head_i.opv);
      MODE_PWS: add_d = mod_sub(job_head_i.opu, job_head_i.opv);
      default:  add_d = '0;
    endcase
  end

  // Stage 4 combine, product is zero for PWA and PWS
  always_comb begin
    res_d.u = (s3_mode == MODE_GS) ? s3_add : mod_add(s3_add, s3_prod);
    case (s3_mode)
      MODE_CT: res_d.v = mod_sub(s3_add, s3_prod);
      MODE_GS: res_d.v = s3_prod;
      default: res_d.v = '0;
    endcase
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      s4_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= job_pop_o;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      s4_valid <= s3_valid;
    end
  end

  // Datapath registers with mode tags
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_ma      <= ma_d;
      s1_mb      <= mb_d;
      s1_add     <= add_d;
      s1_mode    <= job_head_i.mode;
      // Full 46-bit product
      s2_prod    <= s1_ma * s1_mb;
      s2_add     <= s1_add;
      s2_mode    <= s1_mode;
      s3_prod    <= mod_reduce(s2_prod);
      s3_add     <= s2_add;
      s3_mode    <= s2_mode;
      res_data_o <= res_d;
    end
  end

  // Every pushed result is a reduced field element
  res_range_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    res_push_o |-> (res_data_o.u < NTT_Q) && (res_data_o.v < NTT_Q));

endmodule

`default_nettype wire

/* src/ntt_coproc_top.sv */
// NTT butterfly coprocessor top, bus front end feeding a job FIFO, pipeline and result FIFO
`timescale 1ns/100ps
`default_nettype none

module ntt_coproc_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  ntt_pkg::axil_addr_t awaddr_i,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  ntt_pkg::axil_data_t wdata_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  output ntt_pkg::axil_resp_t bresp_o,
  output logic                bvalid_o,
  input  logic                bready_i,
  input  ntt_pkg::axil_addr_t araddr_i,
  input  logic                arvalid_i,
  output logic                arready_o,
  output ntt_pkg::axil_data_t rdata_o,
  output ntt_pkg::axil_resp_t rresp_o,
  output logic                rvalid_o,
  input  logic                rready_i
);
  import ntt_pkg::*;

  // Job path, front end to butterfly
  logic        job_push, job_full, job_pop, job_empty;
  ntt_job_t    job_data, job_head;
  // Result path, butterfly back to front end
  logic        res_push, res_full, res_pop, res_empty;
  ntt_result_t res_data, res_head;

  ntt_axil_frontend ntt_axil_frontend_inst (
    .clk, .rst_n_i,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .job_push_o(job_push), .job_data_o(job_data), .job_full_i(job_full),
    .res_pop_o(res_pop), .res_head_i(res_head), .res_empty_i(res_empty)
  );

  ntt_fifo #(.ITEM_T(ntt_job_t)) ntt_job_fifo_inst (
    .clk, .rst_n_i, .push_i(job_push), .data_i(job_data), .full_o(job_full),
    .pop_i(job_pop), .head_o(job_head), .empty_o(job_empty)
  );

  ntt_butterfly ntt_butterfly_inst (
    .clk, .rst_n_i, .job_head_i(job_head), .job_empty_i(job_empty), .job_pop_o(job_pop),
    .res_push_o(res_push), .res_data_o(res_data), .res_full_i(res_full)
  );

  ntt_fifo #(.ITEM_T(ntt_result_t)) ntt_res_fifo_inst (
    .clk, .rst_n_i, .push_i(res_push), .data_i(res_data), .full_o(res_full),
    .pop_i(res_pop), .head_o(res_head), .empty_o(res_empty)
  );

endmodule

`default_nettype wire

/* src/ntt_fifo.sv */
// Ring-buffer FIFO for packed struct items, with full and empty flags
`timescale 1ns/100ps
`default_nettype none

module ntt_fifo #(
  parameter int unsigned DEPTH  = ntt_pkg::FIFO_DEPTH,
  parameter type         ITEM_T = logic
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  ITEM_T data_i,
  output logic  full_o,
  input  logic  pop_i,
  output ITEM_T head_o,
  output logic  empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // Storage, no reset needed on the payload
  ITEM_T            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from an empty one
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count == (PTR_W+1)'(DEPTH));
  assign empty_o = (count == '0);
  assign head_o  = mem[rd_ptr];

  // Drop pushes when full, ignore pops when empty
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap naturally for a power-of-two depth
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer and consumer keep to the flags
  push_when_full_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_i |-> !full_o);
  pop_when_empty_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/ntt_pkg.sv */
// NTT coprocessor package with field constants, bus widths, job and result types, register map
`default_nettype none

package ntt_pkg;

  // Prime field q = 2^23 - 2^13 + 1
  localparam int unsigned COEF_W = 23;
  typedef logic [COEF_W-1:0]   coef_t;
  typedef logic [2*COEF_W-1:0] prod_t;
  localparam coef_t NTT_Q = 23'd8380417;
  // 2^23 mod q, used to fold the upper product bits
  localparam logic [12:0] NTT_FOLD = 13'd8191;

  // AXI4-Lite bus widths
  localparam int unsigned AXIL_AW = 8;
  localparam int unsigned AXIL_DW = 32;
  typedef logic [AXIL_AW-1:0] axil_addr_t;
  typedef logic [AXIL_DW-1:0] axil_data_t;
  typedef logic [1:0]         axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'd0;
  localparam axil_resp_t RESP_SLVERR = 2'd2;

  // Butterfly operations, codes 5..7 are illegal
  typedef enum logic [2:0] {
    MODE_CT  = 3'd0,
    MODE_GS  = 3'd1,
    MODE_PWM = 3'd2,
    MODE_PWA = 3'd3,
    MODE_PWS = 3'd4
  } ntt_mode_e;

  // One queued job, 73 bits
  typedef struct packed {
    coef_t     opu;
    coef_t     opv;
    coef_t     opw;
    ntt_mode_e mode;
    logic      accumulate;
  } ntt_job_t;

  // One result pair, v is zero for the pointwise modes
  typedef struct packed {
    coef_t u;
    coef_t v;
  } ntt_result_t;

  // Register map
  localparam axil_addr_t REG_OPU    = 8'h00;
  localparam axil_addr_t REG_OPV    = 8'h04;
  localparam axil_addr_t REG_OPW    = 8'h08;
  localparam axil_addr_t REG_CTRL   = 8'h0C;
  localparam axil_addr_t REG_RES_U  = 8'h10;
  localparam axil_addr_t REG_RES_V  = 8'h14;
  localparam axil_addr_t REG_STATUS = 8'h18;

  localparam int unsigned FIFO_DEPTH = 4;

endpackage

`default_nettype wire

/* tests/ntt_coproc_tb.sv */
// Bus-level testbench for the NTT coprocessor, table rows and random jobs against a mod-q model
`timescale 1ns/100ps
`default_nettype none

module ntt_coproc_tb;
  import ntt_pkg::*;

  localparam int unsigned TIMEOUT  = 200;
  localparam int unsigned NUM_ROWS = 16;
  localparam coef_t       QM1      = NTT_Q - 23'd1;

  // One stimulus row with the result it must produce
  typedef struct packed {
    coef_t      opu;
    coef_t      opv;
    coef_t      opw;
    logic [2:0] mode;
    logic       acc;
    coef_t      exp_u;
    coef_t      exp_v;
  } row_t;

  logic        clk;
  logic        rst_n;
  axil_addr_t  awaddr;
  logic        awvalid;
  logic        awready;
  axil_data_t  wdata;
  logic        wvalid;
  logic        wready;
  axil_resp_t  bresp;
  logic        bvalid;
  logic        bready;
  axil_addr_t  araddr;
  logic        arvalid;
  logic        arready;
  axil_data_t  rdata;
  axil_resp_t  rresp;
  logic        rvalid;
  logic        rready;
  logic [31:0] lcg_state = 32'd82070;

  // Edge values 0 and q-1, and 2^22 to exercise the reduction
  row_t rows [NUM_ROWS] = '{
    '{23'd0, 23'd0, 23'd0, MODE_CT, 1'b0, 23'd0, 23'd0},
    '{QM1, 23'd1, 23'd1, MODE_CT, 1'b0, 23'd0, 23'd8380415},
    '{23'd5, QM1, QM1, MODE_CT, 1'b0, 23'd6, 23'd4},
    '{23'd0, 23'd2, 23'd3, MODE_CT, 1'b0, 23'd6, 23'd8380411},
    '{23'd1, 23'd4194304, 23'd4, MODE_CT, 1'b0, 23'd16383, 23'd8364036},
    '{QM1, QM1, 23'd7, MODE_GS, 1'b0, 23'd8380415, 23'd0},
    '{23'd0, 23'd1, 23'd2, MODE_GS, 1'b0, 23'd1, 23'd8380415},
    '{23'd10, 23'd3, QM1, MODE_GS, 1'b0, 23'd13, 23'd8380410},
    '{QM1, QM1, 23'd0, MODE_PWM, 1'b0, 23'd1, 23'd0},
    '{23'd2, 23'd3, 23'd100, MODE_PWM, 1'b0, 23'd6, 23'd0},
    '{23'd1000, 23'd1000, 23'd5, MODE_PWM, 1'b1, 23'd1000005, 23'd0},
    '{23'd3, QM1, QM1, MODE_PWM, 1'b1, 23'd8380413, 23'd0},
    '{23'd4194304, 23'd4, 23'd0, MODE_PWM, 1'b0, 23'd16382, 23'd0},
    '{QM1, 23'd2, 23'd9, MODE_PWA, 1'b0, 23'd1, 23'd0},
    '{23'd0, 23'd1, 23'd9, MODE_PWS, 1'b0, QM1, 23'd0},
    '{23'd7, 23'd7, 23'd0, MODE_PWS, 1'b0, 23'd0, 23'd0}
  };

  tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  ntt_coproc_top ntt_coproc_top_inst (
    .clk(clk), .rst_n_i(rst_n),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      abort_run($sformatf("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Mod-q butterfly formulas in 64-bit arithmetic
  function automatic ntt_result_t model_result(input row_t r);
    longint unsigned q;
    longint unsigned u;
    longint unsigned v;
    longint unsigned w;
    longint unsigned t;
    ntt_result_t     res;
    q = 64'(NTT_Q);
    u = 64'(r.opu);
    v = 64'(r.opv);
    w = 64'(r.opw);
    res = '0;
    case (r.mode)
      MODE_CT: begin
        t = (w * v) % q;
        res.u = 23'((u + t) % q);
        res.v = 23'((u + q - t) % q);
      end
      MODE_GS: begin
        res.u = 23'((u + v) % q);
        res.v = 23'((((u + q - v) % q) * w) % q);
      end
      MODE_PWM: res.u = 23'((u * v + (r.acc ? w : 64'd0)) % q);
      MODE_PWA: res.u = 23'((u + v) % q);
      MODE_PWS: res.u = 23'((u + q - v) % q);
      default:  res = '0;
    endcase
    return res;
  endfunction

  function automatic row_t random_row();
    row_t r;
    r = '0;
    r.opu  = 23'(lcg_next() % 32'(NTT_Q));
    r.opv  = 23'(lcg_next() % 32'(NTT_Q));
    r.opw  = 23'(lcg_next() % 32'(NTT_Q));
    r.mode = 3'((lcg_next() >> 16) % 32'd5);
    r.acc  = 1'(lcg_next() >> 31);
    return r;
  endfunction

  // AW and W taken at the rising edge with awready, B response one cycle later
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
    int unsigned n;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(posedge clk);
    while (!awready && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (awready) else abort_run("timeout waiting for awready");
    check_value("wready", 32'd1, 32'(wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_value("bvalid", 32'd1, 32'(bvalid));
    resp    = bresp;
  endtask

  // AR taken at the rising edge with arready, read data one cycle later
  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    int unsigned n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(posedge clk);
    while (!arready && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (arready) else abort_run("timeout waiting for arready");
    @(negedge clk);
    arvalid = 1'b0;
    check_value("rvalid", 32'd1, 32'(rvalid));
    data    = rdata;
    resp    = rresp;
  endtask

  task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                              input axil_resp_t exp_resp, input string name);
    axil_resp_t resp;
    axil_write(addr, data, resp);
    check_value(name, 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
                             input axil_resp_t exp_resp, input string name);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(addr, data, resp);
    check_value({name, " rresp"}, 32'(exp_resp), 32'(resp));
    check_value({name, " rdata"}, exp_data, data);
  endtask

  // Operands first, the CTRL write queues the job
  task automatic queue_job(input row_t r, output axil_resp_t ctrl_resp);
    write_expect(REG_OPU, 32'(r.opu), RESP_OKAY, "bresp OPU");
    write_expect(REG_OPV, 32'(r.opv), RESP_OKAY, "bresp OPV");
    write_expect(REG_OPW, 32'(r.opw), RESP_OKAY, "bresp OPW");
    axil_write(REG_CTRL, 32'({r.acc, r.mode}), ctrl_resp);
  endtask

  // Poll STATUS bit 1 until the result buffer holds something
  task automatic wait_result();
    axil_data_t  status;
    axil_resp_t  resp;
    int unsigned n;
    status = 32'h2;
    n = 0;
    while (status[1] && n < TIMEOUT) begin
      axil_read(REG_STATUS, status, resp);
      n++;
    end
    assert (!status[1]) else abort_run("timeout waiting for a result in the result buffer");
  endtask

  task automatic check_result(input ntt_result_t exp);
    wait_result();
    read_expect(REG_RES_U, 32'(exp.u), RESP_OKAY, "RES_U");
    // RES_V read pops the head
    read_expect(REG_RES_V, 32'(exp.v), RESP_OKAY, "RES_V");
  endtask

  initial begin
    row_t        r;
    ntt_result_t exp_res;
    ntt_result_t exp_q [$];
    axil_resp_t  resp;
    int unsigned n;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    n = 0;
    while (rst_n !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (rst_n === 1'b1) else abort_run("reset was never released");

    // Job buffer not full, result buffer empty
    read_expect(REG_STATUS, 32'h2, RESP_OKAY, "STATUS");
    read_expect(REG_RES_V, 32'h0, RESP_SLVERR, "RES_V empty");

    // Table rows, one job at a time
    for (int i = 0; i < NUM_ROWS; i++) begin
      queue_job(rows[i], resp);
      check_value("bresp CTRL", 32'(RESP_OKAY), 32'(resp));
      exp_res.u = rows[i].exp_u;
      exp_res.v = rows[i].exp_v;
      check_result(exp_res);
    end

    // A full result buffer freezes the pipeline with one result in the last stage
    // so 4 results, that stage and 4 queued jobs fit
    for (int i = 0; i < 20; i++) begin
      r = random_row();
      queue_job(r, resp);
      if (resp == RESP_SLVERR) break;
      exp_q.push_back(model_result(r));
    end
    check_value("accepted jobs", 32'(2 * FIFO_DEPTH + 1), 32'(exp_q.size()));
    // Job buffer full and results waiting
    read_expect(REG_STATUS, 32'h1, RESP_OKAY, "STATUS full");
    while (exp_q.size() > 0) begin
      check_result(exp_q.pop_front());
    end
    read_expect(REG_STATUS, 32'h2, RESP_OKAY, "STATUS drained");

    // Out-of-range operands leave the old values in place
    write_expect(REG_OPU, 32'd5, RESP_OKAY, "bresp OPU");
    write_expect(REG_OPV, 32'd3, RESP_OKAY, "bresp OPV");
    write_expect(REG_OPU, 32'(NTT_Q), RESP_SLVERR, "bresp OPU q");
    write_expect(REG_OPV, 32'hFFFF_FFFF, RESP_SLVERR, "bresp OPV max");
    write_expect(REG_CTRL, 32'(MODE_PWA), RESP_OKAY, "bresp CTRL PWA");
    exp_res.u = 23'd8;
    exp_res.v = 23'd0;
    check_result(exp_res);
    // Illegal mode queues nothing, so only the PWS result comes back
    write_expect(REG_CTRL, 32'd6, RESP_SLVERR, "bresp CTRL mode 6");
    write_expect(REG_CTRL, 32'(MODE_PWS), RESP_OKAY, "bresp CTRL PWS");
    exp_res.u = 23'd2;
    check_result(exp_res);
    read_expect(REG_STATUS, 32'h2, RESP_OKAY, "STATUS after mode 6");
    write_expect(8'h1C, 32'd1, RESP_SLVERR, "bresp unmapped");
    write_expect(REG_STATUS, 32'd0, RESP_SLVERR, "bresp STATUS write");
    read_expect(8'h20, 32'h0, RESP_SLVERR, "unmapped");
    read_expect(REG_OPU, 32'h0, RESP_SLVERR, "OPU read");

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock and synchronous reset source for the NTT coprocessor
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD = 50,
  parameter int unsigned RST_CYCLES  = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
